// ==== files.f ====
i2c_pkg.sv
i2c_pads.sv
i2c_timing.sv
i2c_shift_unit.sv
i2c_sequencer.sv
i2c_master.sv
i2c_slave_model.sv
i2c_master_props.sv
tb_i2c_master.sv

// ==== i2c_master.sv ====
`timescale 1ns/1ps

module i2c_master (
    input  logic                  clock,
    input  logic                  reset_n,
    input  logic                  enable,
    input  logic                  read_write,
    input  i2c_pkg::device_addr_t device_address,
    input  i2c_pkg::byte_t        register_address,
    input  i2c_pkg::byte_t        write_data,
    input  i2c_pkg::divider_t     divider,
    output logic                  busy,
    output i2c_pkg::byte_t        read_data,
    inout  wire                   scl,
    inout  wire                   sda
);

    logic tick;
    logic expired;
    logic timer_load;
    logic capture;
    logic shift_out;
    logic set_read_bit;
    logic sample;
    logic tx_bit;
    logic scl_out;
    logic sda_out;
    logic scl_drive;
    logic sda_drive;
    logic scl_in;
    logic sda_in;

    i2c_sequencer u_sequencer (
        .clock        (clock),
        .reset_n      (reset_n),
        .enable       (enable),
        .read_write   (read_write),
        .tick         (tick),
        .expired      (expired),
        .tx_bit       (tx_bit),
        .scl_in       (scl_in),
        .sda_in       (sda_in),
        .busy         (busy),
        .timer_load   (timer_load),
        .capture      (capture),
        .shift_out    (shift_out),
        .set_read_bit (set_read_bit),
        .sample       (sample),
        .scl_out      (scl_out),
        .sda_out      (sda_out),
        .scl_drive    (scl_drive),
        .sda_drive    (sda_drive)
    );

    i2c_timing u_timing (
        .clock      (clock),
        .reset_n    (reset_n),
        .timer_load (timer_load),
        .divider    (divider),
        .tick       (tick),
        .expired    (expired)
    );

    i2c_shift_unit u_shift_unit (
        .clock            (clock),
        .reset_n          (reset_n),
        .capture          (capture),
        .shift_out        (shift_out),
        .set_read_bit     (set_read_bit),
        .sample           (sample),
        .sda_in           (sda_in),
        .device_address   (device_address),
        .register_address (register_address),
        .write_data       (write_data),
        .tx_bit           (tx_bit),
        .read_data        (read_data)
    );

    i2c_pads u_pads (
        .clock     (clock),
        .reset_n   (reset_n),
        .scl_out   (scl_out),
        .sda_out   (sda_out),
        .scl_drive (scl_drive),
        .sda_drive (sda_drive),
        .scl       (scl),
        .sda       (sda),
        .scl_in    (scl_in),
        .sda_in    (sda_in)
    );

endmodule

// ==== i2c_master_props.sv ====
`timescale 1ns/1ps

module i2c_master_props (
    input logic                clock,
    input logic                reset_n,
    input logic                enable,
    input logic                busy,
    input logic                scl_drive,
    input logic                sda_drive,
    input i2c_pkg::byte_t      read_data,
    input i2c_pkg::seq_state_t seq_state
);

    import i2c_pkg::*;

    int failure_count = 0;

    busy_low_after_reset: assert property (
        @(posedge clock) !reset_n |=> !busy
    ) else begin
        failure_count++;
        $error("busy is not low after reset");
    end

    pads_released_when_idle: assert property (
        @(posedge clock) disable iff (!reset_n)
        !busy |-> (!scl_drive && !sda_drive)
    ) else begin
        failure_count++;
        $error("a pad is driven while busy is low");
    end

    enable_raises_busy: assert property (
        @(posedge clock) disable iff (!reset_n)
        (enable && !busy) |=> busy
    ) else begin
        failure_count++;
        $error("busy did not rise after an accepted enable");
    end

    // Only the read-data state shifts in new bits
    read_data_stable: assert property (
        @(posedge clock) disable iff (!reset_n)
        (seq_state != S_READ_DATA) |=> $stable(read_data)
    ) else begin
        failure_count++;
        $error("read_data changed outside the read-data state");
    end

endmodule

bind i2c_master i2c_master_props u_props (
    .clock     (clock),
    .reset_n   (reset_n),
    .enable    (enable),
    .busy      (busy),
    .scl_drive (scl_drive),
    .sda_drive (sda_drive),
    .read_data (read_data),
    .seq_state (u_sequencer.state)
);

// ==== i2c_pads.sv ====
`timescale 1ns/1ps

module i2c_pads (
    input  logic clock,
    input  logic reset_n,
    input  logic scl_out,
    input  logic sda_out,
    input  logic scl_drive,
    input  logic sda_drive,
    inout  wire  scl,
    inout  wire  sda,
    output logic scl_in,
    output logic sda_in
);

    logic [1:0] scl_sync;
    logic [1:0] sda_sync;

    // Open drain, only a low level is ever driven
    assign scl = (scl_drive && !scl_out) ? 1'b0 : 1'bz;
    assign sda = (sda_drive && !sda_out) ? 1'b0 : 1'bz;

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            scl_sync <= 2'b11;
            sda_sync <= 2'b11;
        end else begin
            scl_sync <= {scl_sync[0], scl};
            sda_sync <= {sda_sync[0], sda};
        end
    end

    assign scl_in = scl_sync[1];
    assign sda_in = sda_sync[1];

endmodule

// ==== i2c_pkg.sv ====
package i2c_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths and limits
    ////////////////////////////////////////////////////////////////////////////

    localparam int DIVIDER_WIDTH = 16;
    localparam int STRETCH_WIDTH = 16;
    localparam int FRAME_BITS    = 8;

    // Address byte, register byte and data byte back to back
    localparam int TX_CHAIN_BITS = 3 * FRAME_BITS;

    typedef logic [6:0]               device_addr_t;
    typedef logic [FRAME_BITS-1:0]    byte_t;
    typedef logic [DIVIDER_WIDTH-1:0] divider_t;
    typedef logic [STRETCH_WIDTH-1:0] stretch_count_t;
    typedef logic [3:0]               bit_count_t;
    typedef logic [1:0]               phase_t;

    // Divider ticks allowed with SCL held low in the wait phase
    localparam stretch_count_t STRETCH_LIMIT = 16'd255;

    typedef enum logic [3:0] {
        S_IDLE,
        S_START,
        S_ADDR_WRITE,
        S_REG_WRITE,
        S_DATA_WRITE,
        S_CHECK_ACK,
        S_RESTART,
        S_ADDR_READ,
        S_READ_DATA,
        S_SEND_NACK,
        S_SEND_STOP
    } seq_state_t;

endpackage

// ==== i2c_sequencer.sv ====
`timescale 1ns/1ps

module i2c_sequencer (
    input  logic clock,
    input  logic reset_n,
    input  logic enable,
    input  logic read_write,
    input  logic tick,
    input  logic expired,
    input  logic tx_bit,
    input  logic scl_in,
    input  logic sda_in,
    output logic busy,
    output logic timer_load,
    output logic capture,
    output logic shift_out,
    output logic set_read_bit,
    output logic sample,
    output logic scl_out,
    output logic sda_out,
    output logic scl_drive,
    output logic sda_drive
);

    import i2c_pkg::*;

    seq_state_t state;
    seq_state_t post_state;
    phase_t     phase;
    bit_count_t bit_count;
    logic       rw_q;
    logic       ack_low;
    logic       load_tx;
    logic       in_frame;

    assign busy         = (state != S_IDLE);
    assign capture      = (state == S_IDLE) && enable;
    assign timer_load   = (phase == 2'd0);
    assign set_read_bit = tick && (phase == 2'd3) && (state == S_RESTART);
    assign sample       = tick && (phase == 2'd2) && (state == S_READ_DATA);
    assign scl_drive    = (state != S_IDLE);
    assign sda_drive    = !(state inside {S_IDLE, S_CHECK_ACK, S_READ_DATA});
    assign in_frame     = state inside {S_ADDR_WRITE, S_REG_WRITE, S_DATA_WRITE,
                                        S_ADDR_READ, S_READ_DATA};

    // Next outgoing bit is put on SDA while SCL is low
    always_comb begin
        load_tx = 1'b0;
        if (tick && phase == 2'd3) begin
            case (state)
                S_START:      load_tx = 1'b1;
                S_ADDR_WRITE,
                S_REG_WRITE,
                S_DATA_WRITE,
                S_ADDR_READ:  load_tx = (bit_count != '0);
                S_CHECK_ACK:  load_tx = ack_low && (post_state inside {S_REG_WRITE,
                                                                       S_DATA_WRITE});
                default:      load_tx = 1'b0;
            endcase
        end
    end

    assign shift_out = load_tx;

    ////////////////////////////////////////////////////////////////////////////
    // Transaction FSM, four ticks per bus bit
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state      <= S_IDLE;
            post_state <= S_IDLE;
            phase      <= '0;
            bit_count  <= '0;
            rw_q       <= 1'b0;
            ack_low    <= 1'b0;
            scl_out    <= 1'b1;
            sda_out    <= 1'b1;
        end else if (state == S_IDLE) begin
            phase   <= '0;
            scl_out <= 1'b1;
            sda_out <= 1'b1;
            if (enable) begin
                state      <= S_START;
                post_state <= S_ADDR_WRITE;
                rw_q       <= read_write;
            end
        end else if (tick) begin
            phase <= phase + 2'd1;
            if (state == S_START) begin
                case (phase)
                    2'd1: sda_out <= 1'b0;
                    2'd2: bit_count <= bit_count_t'(FRAME_BITS);
                    2'd3: begin
                        scl_out <= 1'b0;
                        state   <= post_state;
                    end
                    default: ;
                endcase
            end else begin
                case (phase)
                    2'd0: scl_out <= 1'b1;
                    2'd1: begin
                        // Slave still holds SCL low
                        if (!scl_in) begin
                            phase <= phase;
                            if (expired) begin
                                state <= S_IDLE;
                                phase <= '0;
                            end
                        end
                    end
                    2'd2: begin
                        if (state == S_SEND_STOP) begin
                            sda_out <= 1'b1;
                        end else if (state != S_RESTART) begin
                            scl_out <= 1'b0;
                        end
                        if (in_frame) begin
                            bit_count <= bit_count - bit_count_t'(1);
                        end
                        if (state == S_CHECK_ACK) begin
                            ack_low <= !sda_in;
                        end
                    end
                    2'd3: begin
                        case (state)
                            S_ADDR_WRITE,
                            S_REG_WRITE,
                            S_DATA_WRITE,
                            S_ADDR_READ: begin
                                if (bit_count == '0) begin
                                    state <= S_CHECK_ACK;
                                    case (state)
                                        S_ADDR_WRITE: post_state <= S_REG_WRITE;
                                        S_REG_WRITE:  post_state <= rw_q ? S_RESTART
                                                                         : S_DATA_WRITE;
                                        S_DATA_WRITE: post_state <= S_SEND_STOP;
                                        default:      post_state <= S_READ_DATA;
                                    endcase
                                end
                            end
                            S_CHECK_ACK: begin
                                bit_count <= bit_count_t'(FRAME_BITS);
                                if (ack_low) begin
                                    state   <= post_state;
                                    sda_out <= (post_state != S_SEND_STOP);
                                end else begin
                                    // NACK ends the transaction
                                    state   <= S_SEND_STOP;
                                    sda_out <= 1'b0;
                                end
                            end
                            S_READ_DATA: begin
                                if (bit_count == '0) begin
                                    state   <= S_SEND_NACK;
                                    sda_out <= 1'b1;
                                end
                            end
                            S_SEND_NACK: begin
                                state   <= S_SEND_STOP;
                                sda_out <= 1'b0;
                            end
                            S_RESTART: begin
                                state      <= S_START;
                                post_state <= S_ADDR_READ;
                            end
                            default: state <= S_IDLE;
                        endcase
                    end
                    default: ;
                endcase
            end
            if (load_tx) begin
                sda_out <= tx_bit;
            end
        end
    end

endmodule

// ==== i2c_shift_unit.sv ====
`timescale 1ns/1ps

module i2c_shift_unit (
    input  logic                  clock,
    input  logic                  reset_n,
    input  logic                  capture,
    input  logic                  shift_out,
    input  logic                  set_read_bit,
    input  logic                  sample,
    input  logic                  sda_in,
    input  i2c_pkg::device_addr_t device_address,
    input  i2c_pkg::byte_t        register_address,
    input  i2c_pkg::byte_t        write_data,
    output logic                  tx_bit,
    output i2c_pkg::byte_t        read_data
);

    import i2c_pkg::*;

    // Rotating chain, one bit per shift_out, MSB is on the wire next
    logic [TX_CHAIN_BITS-1:0] tx_chain;

    assign tx_bit = tx_chain[TX_CHAIN_BITS-1];

    ////////////////////////////////////////////////////////////////////////////
    // Outgoing bytes
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (capture) begin
            tx_chain <= {device_address, 1'b0, register_address, write_data};
        end else if (set_read_bit) begin
            // Two frames sent, so the address byte now sits in the middle
            tx_chain <= {tx_chain[2*FRAME_BITS-1:FRAME_BITS+1], 1'b1,
                         tx_chain[2*FRAME_BITS-1:0]};
        end else if (shift_out) begin
            tx_chain <= {tx_chain[TX_CHAIN_BITS-2:0], tx_chain[TX_CHAIN_BITS-1]};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Incoming byte
    ////////////////////////////////////////////////////////////////////////////

    // MSB arrives first
    always_ff @(posedge clock) begin
        if (!reset_n) begin
            read_data <= '0;
        end else if (sample) begin
            read_data <= {read_data[FRAME_BITS-2:0], sda_in};
        end
    end

endmodule

// ==== i2c_slave_model.sv ====
`timescale 1ns/1ps

module i2c_slave_model #(
    parameter logic [6:0] SLAVE_ADDRESS = 7'h42
) (
    input  logic        clock,
    input  logic        reset_n,
    input  logic [15:0] stretch_cycles,
    input  logic        hold_scl,
    inout  wire         scl,
    inout  wire         sda
);

    typedef enum logic [2:0] {
        SL_IDLE,
        SL_RECEIVE,
        SL_ACK,
        SL_SEND,
        SL_MASTER_ACK
    } slave_state_t;

    logic [7:0]   regs [16];
    slave_state_t state;
    logic [7:0]   rx_byte;
    logic [7:0]   tx_byte;
    logic [7:0]   reg_pointer;
    int           bit_count;
    int           byte_index;
    logic         read_mode;
    logic         scl_prev;
    logic         sda_prev;
    logic         sda_low;
    logic [15:0]  stretch_left;
    logic         scl_now;
    logic         sda_now;

    assign scl = (hold_scl || stretch_left != '0) ? 1'b0 : 1'bz;
    assign sda = sda_low ? 1'b0 : 1'bz;

    assign scl_now = (scl !== 1'b0);
    assign sda_now = (sda !== 1'b0);

    // Fill pattern built from the whole register index
    initial begin
        for (int i = 0; i < 16; i++) begin
            regs[i] = {~4'(i), 4'(i)};
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Bus oversampling, lines are settled by the falling system clock
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clock) begin
        if (!reset_n) begin
            state        <= SL_IDLE;
            sda_low      <= 1'b0;
            stretch_left <= '0;
            scl_prev     <= 1'b1;
            sda_prev     <= 1'b1;
            bit_count    <= 0;
            byte_index   <= 0;
            read_mode    <= 1'b0;
            reg_pointer  <= '0;
            rx_byte      <= '0;
            tx_byte      <= '0;
        end else if (hold_scl) begin
            state        <= SL_IDLE;
            sda_low      <= 1'b0;
            stretch_left <= '0;
            scl_prev     <= scl_now;
            sda_prev     <= sda_now;
        end else begin
            scl_prev <= scl_now;
            sda_prev <= sda_now;
            if (stretch_left != '0) begin
                stretch_left <= stretch_left - 16'd1;
            end
            if (scl_prev && scl_now && sda_prev && !sda_now) begin
                // START or repeated START
                state      <= SL_RECEIVE;
                bit_count  <= 0;
                byte_index <= 0;
                sda_low    <= 1'b0;
            end else if (scl_prev && scl_now && !sda_prev && sda_now) begin
                state   <= SL_IDLE;
                sda_low <= 1'b0;
            end else if (!scl_prev && scl_now) begin
                case (state)
                    SL_RECEIVE: begin
                        rx_byte   <= {rx_byte[6:0], sda_now};
                        bit_count <= bit_count + 1;
                    end
                    SL_MASTER_ACK: state <= SL_IDLE;
                    default: ;
                endcase
            end else if (scl_prev && !scl_now) begin
                if (stretch_cycles != '0) begin
                    stretch_left <= stretch_cycles;
                end
                case (state)
                    SL_RECEIVE: begin
                        if (bit_count == 8) begin
                            bit_count <= 0;
                            if (byte_index == 0 && rx_byte[7:1] != SLAVE_ADDRESS) begin
                                state <= SL_IDLE;
                            end else begin
                                if (byte_index == 0) begin
                                    read_mode <= rx_byte[0];
                                end else if (byte_index == 1) begin
                                    reg_pointer <= rx_byte;
                                end else begin
                                    regs[reg_pointer[3:0]] <= rx_byte;
                                end
                                sda_low <= 1'b1;
                                state   <= SL_ACK;
                            end
                        end
                    end
                    SL_ACK: begin
                        if (byte_index == 0 && read_mode) begin
                            tx_byte   <= regs[reg_pointer[3:0]];
                            sda_low   <= !regs[reg_pointer[3:0]][7];
                            bit_count <= 1;
                            state     <= SL_SEND;
                        end else begin
                            sda_low    <= 1'b0;
                            byte_index <= byte_index + 1;
                            state      <= SL_RECEIVE;
                        end
                    end
                    SL_SEND: begin
                        if (bit_count == 8) begin
                            sda_low <= 1'b0;
                            state   <= SL_MASTER_ACK;
                        end else begin
                            sda_low   <= !tx_byte[7-bit_count];
                            bit_count <= bit_count + 1;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

// ==== i2c_timing.sv ====
`timescale 1ns/1ps

module i2c_timing (
    input  logic              clock,
    input  logic              reset_n,
    input  logic              timer_load,
    input  i2c_pkg::divider_t divider,
    output logic              tick,
    output logic              expired
);

    import i2c_pkg::*;

    divider_t       div_count;
    stretch_count_t stretch_count;

    ////////////////////////////////////////////////////////////////////////////
    // Bit phase tick
    ////////////////////////////////////////////////////////////////////////////

    // Compare with >= so a smaller divider written mid-count takes effect
    assign tick = (div_count >= divider);

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            div_count <= '0;
        end else if (tick) begin
            div_count <= '0;
        end else begin
            div_count <= div_count + divider_t'(1);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Clock stretch timeout
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            stretch_count <= STRETCH_LIMIT;
        end else if (timer_load) begin
            stretch_count <= STRETCH_LIMIT;
        end else if (tick && !expired) begin
            stretch_count <= stretch_count - stretch_count_t'(1);
        end
    end

    assign expired = (stretch_count == '0);

endmodule

// ==== tb_i2c_master.sv ====
`timescale 1ns/1ps

module tb_i2c_master;

    import i2c_pkg::*;

    localparam int           CLOCK_PERIOD   = 4;
    localparam divider_t     DIVIDER        = 16'd3;
    localparam device_addr_t SLAVE_ADDRESS  = 7'h42;
    localparam device_addr_t ABSENT_ADDRESS = 7'h13;
    localparam int           BIT_CYCLES     = 4 * (DIVIDER + 1);
    localparam int           TRANSACTION_LIMIT = 40 * BIT_CYCLES * 4;
    // STRETCH_LIMIT ticks plus ten bit times
    localparam int           TIMEOUT_LIMIT  = (int'(STRETCH_LIMIT) + 10 * 4) * (DIVIDER + 1);
    // 40 transactions of up to 40 bits, plus half again as margin
    localparam longint       WATCHDOG_NS    = 40 * 40 * BIT_CYCLES * CLOCK_PERIOD * 3 / 2;

    logic         clock;
    logic         reset_n;
    logic         enable;
    logic         read_write;
    device_addr_t device_address;
    byte_t        register_address;
    byte_t        write_data;
    divider_t     divider;
    logic         busy;
    byte_t        read_data;
    wire          scl;
    wire          sda;
    logic [15:0]  stretch_cycles;
    logic         hold_scl;
    logic [31:0]  rng_state;
    byte_t        expected_regs [16];
    int           error_count;

    pullup (scl);
    pullup (sda);

    i2c_master UUT (
        .clock            (clock),
        .reset_n          (reset_n),
        .enable           (enable),
        .read_write       (read_write),
        .device_address   (device_address),
        .register_address (register_address),
        .write_data       (write_data),
        .divider          (divider),
        .busy             (busy),
        .read_data        (read_data),
        .scl              (scl),
        .sda              (sda)
    );

    i2c_slave_model #(.SLAVE_ADDRESS(SLAVE_ADDRESS)) u_slave (
        .clock          (clock),
        .reset_n        (reset_n),
        .stretch_cycles (stretch_cycles),
        .hold_scl       (hold_scl),
        .scl            (scl),
        .sda            (sda)
    );

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] value);
        logic [31:0] x;
        x = value;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            error_count++;
            $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    // One request, then wait for busy to fall
    task automatic run_transaction(input logic rw, input device_addr_t address,
                                   input byte_t reg_addr, input byte_t data,
                                   input int max_cycles);
        int cycles;
        @(posedge clock);
        #1;
        enable           = 1'b1;
        read_write       = rw;
        device_address   = address;
        register_address = reg_addr;
        write_data       = data;
        @(posedge clock);
        #1;
        enable = 1'b0;
        cycles = 0;
        while (busy && cycles < max_cycles) begin
            @(posedge clock);
            #1;
            cycles++;
        end
        assert (!busy) else begin
            error_count++;
            $display("Transaction to address %0h still busy after %0d cycles",
                     address, max_cycles);
        end
    endtask

    task automatic write_then_read(input string name);
        byte_t reg_addr;
        byte_t data;
        rng_state = xorshift32(rng_state);
        reg_addr  = byte_t'(rng_state[3:0]);
        data      = rng_state[15:8];
        run_transaction(1'b0, SLAVE_ADDRESS, reg_addr, data, TRANSACTION_LIMIT);
        expected_regs[reg_addr[3:0]] = data;
        check_equal({name, " write"}, data, u_slave.regs[reg_addr[3:0]]);
        run_transaction(1'b1, SLAVE_ADDRESS, reg_addr, ~data, TRANSACTION_LIMIT);
        check_equal({name, " read"}, expected_regs[reg_addr[3:0]], read_data);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        byte_t previous_read;
        error_count      = 0;
        rng_state        = 32'd32;
        reset_n          = 1'b0;
        enable           = 1'b0;
        read_write       = 1'b0;
        device_address   = '0;
        register_address = '0;
        write_data       = '0;
        divider          = DIVIDER;
        stretch_cycles   = '0;
        hold_scl         = 1'b0;
        repeat (8) @(posedge clock);
        #1;
        reset_n = 1'b1;
        for (int i = 0; i < 16; i++) begin
            expected_regs[i] = u_slave.regs[i];
        end

        @(posedge clock);
        #1;
        check_equal("reset busy", 0, busy);
        check_equal("reset scl", 1, scl);
        check_equal("reset sda", 1, sda);

        for (int i = 0; i < 16; i++) begin
            write_then_read($sformatf("pair %0d", i));
        end

        // Nobody answers this address
        run_transaction(1'b0, ABSENT_ADDRESS, 8'h05, 8'h5a, TRANSACTION_LIMIT);
        check_equal("absent write busy", 0, busy);
        check_equal("absent write scl", 1, scl);
        check_equal("absent write sda", 1, sda);
        for (int i = 0; i < 16; i++) begin
            check_equal($sformatf("absent write reg %0d", i), expected_regs[i],
                        u_slave.regs[i]);
        end
        previous_read = read_data;
        run_transaction(1'b1, ABSENT_ADDRESS, 8'h05, 8'h00, TRANSACTION_LIMIT);
        check_equal("absent read data", previous_read, read_data);

        // Six ticks of stretch per bit
        stretch_cycles = 16'd24;
        for (int i = 0; i < 2; i++) begin
            write_then_read($sformatf("stretch pair %0d", i));
        end
        stretch_cycles = '0;

        hold_scl = 1'b1;
        run_transaction(1'b0, SLAVE_ADDRESS, 8'h03, 8'hc3, TIMEOUT_LIMIT);
        check_equal("stretch timeout busy", 0, busy);
        @(posedge clock);
        #1;
        hold_scl = 1'b0;
        repeat (4) @(posedge clock);
        #1;
        check_equal("released scl", 1, scl);
        check_equal("released sda", 1, sda);

        $display("Errors: %0d check, %0d assertion", error_count,
                 UUT.u_props.failure_count);
        if (error_count == 0 && UUT.u_props.failure_count == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired before the tests finished");
        $display("Test failed");
        $finish;
    end

endmodule
